/* common/ctrlBus.sv */
`default_nettype none

// clk is only needed by the checks inside the control-word table
interface ctrlBus (
	input logic clk
);

	mipsCtrlPkg::phaseT     phase;
	mipsCtrlPkg::stepT      step;
	mipsCtrlPkg::instrKindT kind;
	logic                   lastStep;

	modport seq (output phase, output step, input lastStep);

	modport dec (output kind, input phase, input lastStep);

	// "table" is a reserved word, hence tbl
	modport tbl (input clk, input phase, input step, input kind, output lastStep);

endinterface

`default_nettype wire

/* common/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

	// major opcodes handled by the control unit
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opBle   = 6'h06,
		opBgt   = 6'h07,
		opAddi  = 6'h08,
		opAddiu = 6'h09,
		opSlti  = 6'h0a,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [4:0] {
		kBeq,
		kBne,
		kBle,
		kBgt,
		kLw,
		kSw,
		kLui,
		kJ,
		kJal,
		kAdd,
		kSub,
		kAnd,
		kSlt,
		kAddi,
		kAddiu,
		kSlti,
		kNoop
	} instrKindT;

	typedef enum logic [2:0] {
		phReset,
		phFetch,
		phWait,
		phDecode,
		phExecute
	} phaseT;

	// encoding expected by the datapath ALU
	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluSlt  = 3'd4,
		aluCmp  = 3'd7
	} aluOpT;

	localparam int STEP_WIDTH = 3;

	typedef logic [STEP_WIDTH-1:0] stepT;

	typedef struct packed {
		logic       pcWriteCond;
		logic       pcWrite;
		logic       irWrite;
		logic       regWrite;
		logic       regAWrite;
		logic       regBWrite;
		logic       aluOutWrite;
		logic       mdrWrite;
		logic       memRead;
		logic       memWrite;
		logic [1:0] pcCondMux;
		logic [2:0] iorDMux;
		logic       readSMux;
		logic [1:0] readDstMux;
		logic [2:0] memToRegMux;
		logic       aluSrcAMux;
		logic [1:0] aluSrcBMux;
		logic [2:0] pcSourceMux;
		aluOpT      aluOp;
	} controlWordT;

endpackage

`default_nettype wire

/* filelist.f */
common/mipsCtrlPkg.sv
common/ctrlBus.sv
hdl/instrDecoder.sv
hdl/stepSequencer.sv
hdl/controlWordTable.sv
hdl/mipsControl.sv
tests/mipsControlTb.sv

/* hdl/controlWordTable.sv */
`default_nettype none

module controlWordTable #(
	parameter int MemWaitSteps = 1
) (
	ctrlBus.tbl bus,
	output mipsCtrlPkg::controlWordT word
);

	localparam mipsCtrlPkg::stepT lastWaitStep = mipsCtrlPkg::stepT'(MemWaitSteps - 1);
	localparam mipsCtrlPkg::stepT stepFirst = mipsCtrlPkg::stepT'(0);
	localparam mipsCtrlPkg::stepT stepSecond = mipsCtrlPkg::stepT'(1);
	// lw and sw: address, access, the waits, then the write
	localparam mipsCtrlPkg::stepT memLastStep = mipsCtrlPkg::stepT'(MemWaitSteps + 2);

	mipsCtrlPkg::stepT execLast;
	logic isImm;

	// index of the final execute step per kind
	always_comb begin
		case (bus.kind)
			mipsCtrlPkg::kLw, mipsCtrlPkg::kSw: execLast = memLastStep;
			mipsCtrlPkg::kJal, mipsCtrlPkg::kAdd, mipsCtrlPkg::kSub, mipsCtrlPkg::kAnd,
			mipsCtrlPkg::kSlt, mipsCtrlPkg::kAddi, mipsCtrlPkg::kAddiu,
			mipsCtrlPkg::kSlti: execLast = stepSecond;
			default: execLast = stepFirst;
		endcase
	end

	assign isImm = bus.kind inside {mipsCtrlPkg::kAddi, mipsCtrlPkg::kAddiu, mipsCtrlPkg::kSlti};

	assign bus.lastStep = (bus.phase == mipsCtrlPkg::phExecute) && (bus.step == execLast);

	always_comb begin
		word = '0;
		case (bus.phase)
			mipsCtrlPkg::phFetch: begin
				// pc + 4 while the instruction is read
				word.pcWrite = 1'b1;
				word.memRead = 1'b1;
				word.aluSrcBMux = 2'b01;
				word.aluOp = mipsCtrlPkg::aluAdd;
			end
			mipsCtrlPkg::phWait: begin
				word.memRead = 1'b1;
				word.irWrite = (bus.step == lastWaitStep);
			end
			mipsCtrlPkg::phDecode: begin
				// registers read and branch target computed up front
				word.regAWrite = 1'b1;
				word.regBWrite = 1'b1;
				word.aluOutWrite = 1'b1;
				word.readSMux = 1'b1;
				word.aluSrcBMux = 2'b11;
				word.aluOp = mipsCtrlPkg::aluAdd;
			end
			mipsCtrlPkg::phExecute: begin
				case (bus.kind)
					mipsCtrlPkg::kBeq, mipsCtrlPkg::kBne, mipsCtrlPkg::kBle,
					mipsCtrlPkg::kBgt: begin
						word.pcWriteCond = 1'b1;
						word.aluSrcAMux = 1'b1;
						word.pcSourceMux = 3'b001;
						case (bus.kind)
							mipsCtrlPkg::kBeq: word.pcCondMux = 2'b11;
							mipsCtrlPkg::kBne: word.pcCondMux = 2'b10;
							mipsCtrlPkg::kBle: word.pcCondMux = 2'b01;
							default: word.pcCondMux = 2'b00;
						endcase
						// beq only needs the zero flag
						word.aluOp = (bus.kind == mipsCtrlPkg::kBeq) ?
							mipsCtrlPkg::aluSub : mipsCtrlPkg::aluCmp;
					end
					mipsCtrlPkg::kLw, mipsCtrlPkg::kSw: begin
						if (bus.step == stepFirst) begin
							word.aluOutWrite = 1'b1;
							word.aluSrcAMux = 1'b1;
							word.aluSrcBMux = 2'b10;
							word.aluOp = mipsCtrlPkg::aluAdd;
						end else if (bus.step == stepSecond) begin
							word.iorDMux = 3'b100;
							word.memRead = 1'b1;
						end else if (bus.step == memLastStep) begin
							if (bus.kind == mipsCtrlPkg::kLw) begin
								word.regWrite = 1'b1;
								word.memToRegMux = 3'b010;
							end else begin
								word.memWrite = 1'b1;
							end
						end else begin
							// memory wait, data lands in mdr
							word.mdrWrite = 1'b1;
							word.memRead = 1'b1;
						end
					end
					mipsCtrlPkg::kLui: begin
						word.regWrite = 1'b1;
						word.memToRegMux = 3'b100;
					end
					mipsCtrlPkg::kJ: begin
						word.pcWrite = 1'b1;
						word.pcSourceMux = 3'b100;
					end
					mipsCtrlPkg::kJal: begin
						if (bus.step == stepFirst) begin
							word.aluOutWrite = 1'b1;
						end else begin
							word.regWrite = 1'b1;
							word.pcWrite = 1'b1;
							word.readDstMux = 2'b01;
							word.pcSourceMux = 3'b010;
						end
					end
					mipsCtrlPkg::kAdd, mipsCtrlPkg::kSub, mipsCtrlPkg::kAnd, mipsCtrlPkg::kSlt,
					mipsCtrlPkg::kAddi, mipsCtrlPkg::kAddiu, mipsCtrlPkg::kSlti: begin
						if (bus.step == stepFirst) begin
							word.aluOutWrite = 1'b1;
							word.aluSrcAMux = 1'b1;
							word.aluSrcBMux = isImm ? 2'b10 : 2'b00;
							case (bus.kind)
								mipsCtrlPkg::kSub: word.aluOp = mipsCtrlPkg::aluSub;
								mipsCtrlPkg::kAnd: word.aluOp = mipsCtrlPkg::aluAnd;
								mipsCtrlPkg::kSlt, mipsCtrlPkg::kSlti: word.aluOp = mipsCtrlPkg::aluSlt;
								default: word.aluOp = mipsCtrlPkg::aluAdd;
							endcase
						end else begin
							// rd for R-type, rt for immediates
							word.regWrite = 1'b1;
							word.readDstMux = isImm ? 2'b00 : 2'b10;
						end
					end
					default: begin
						word = '0;
					end
				endcase
			end
			default: begin
				word = '0;
			end
		endcase
	end

	noMemReadWrite: assert property (
		@(posedge bus.clk) !(word.memRead && word.memWrite)
	);

	noPcWriteBoth: assert property (
		@(posedge bus.clk) !(word.pcWrite && word.pcWriteCond)
	);

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
`default_nettype none

module instrDecoder (
	input logic clk,
	input logic reset,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	ctrlBus.dec bus
);

	mipsCtrlPkg::instrKindT decodedKind;

	// op and funct straight from the instruction register
	always_comb begin
		case (op)
			mipsCtrlPkg::opBeq: decodedKind = mipsCtrlPkg::kBeq;
			mipsCtrlPkg::opBne: decodedKind = mipsCtrlPkg::kBne;
			mipsCtrlPkg::opBle: decodedKind = mipsCtrlPkg::kBle;
			mipsCtrlPkg::opBgt: decodedKind = mipsCtrlPkg::kBgt;
			mipsCtrlPkg::opLw: decodedKind = mipsCtrlPkg::kLw;
			mipsCtrlPkg::opSw: decodedKind = mipsCtrlPkg::kSw;
			mipsCtrlPkg::opLui: decodedKind = mipsCtrlPkg::kLui;
			mipsCtrlPkg::opJ: decodedKind = mipsCtrlPkg::kJ;
			mipsCtrlPkg::opJal: decodedKind = mipsCtrlPkg::kJal;
			mipsCtrlPkg::opAddi: decodedKind = mipsCtrlPkg::kAddi;
			mipsCtrlPkg::opAddiu: decodedKind = mipsCtrlPkg::kAddiu;
			mipsCtrlPkg::opSlti: decodedKind = mipsCtrlPkg::kSlti;
			mipsCtrlPkg::opRType: begin
				case (funct)
					mipsCtrlPkg::fnAdd: decodedKind = mipsCtrlPkg::kAdd;
					mipsCtrlPkg::fnSub: decodedKind = mipsCtrlPkg::kSub;
					mipsCtrlPkg::fnAnd: decodedKind = mipsCtrlPkg::kAnd;
					mipsCtrlPkg::fnSlt: decodedKind = mipsCtrlPkg::kSlt;
					default: decodedKind = mipsCtrlPkg::kNoop;
				endcase
			end
			default: decodedKind = mipsCtrlPkg::kNoop;
		endcase
	end

	// latch on the edge that ends decode, drop back to noop once done
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			bus.kind <= mipsCtrlPkg::kNoop;
		end else if (bus.phase == mipsCtrlPkg::phDecode) begin
			bus.kind <= decodedKind;
		end else if (bus.phase == mipsCtrlPkg::phExecute && bus.lastStep) begin
			bus.kind <= mipsCtrlPkg::kNoop;
		end
	end

	// the table must see one kind for the whole execute sequence
	kindHeldInExecute: assert property (
		@(posedge clk) disable iff (reset)
		bus.phase == mipsCtrlPkg::phExecute
			|=> bus.phase != mipsCtrlPkg::phExecute || $stable(bus.kind)
	);

endmodule

`default_nettype wire

/* hdl/mipsControl.sv */
`default_nettype none

module mipsControl #(
	parameter int MemWaitSteps = 1
) (
	input logic clk,
	input logic reset,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	output logic pcWriteCond,
	output logic pcWrite,
	output logic irWrite,
	output logic regWrite,
	output logic regAWrite,
	output logic regBWrite,
	output logic aluOutWrite,
	output logic mdrWrite,
	output logic memRead,
	output logic memWrite,
	output logic [1:0] pcCondMux,
	output logic [2:0] iorDMux,
	output logic readSMux,
	output logic [1:0] readDstMux,
	output logic [2:0] memToRegMux,
	output logic aluSrcAMux,
	output logic [1:0] aluSrcBMux,
	output logic [2:0] pcSourceMux,
	output mipsCtrlPkg::aluOpT aluOp,
	output mipsCtrlPkg::phaseT phase,
	output logic instrDone
);

	mipsCtrlPkg::controlWordT word;

	ctrlBus bus (.clk(clk));

	stepSequencer #(.MemWaitSteps(MemWaitSteps)) i_stepSequencer (
		.clk(clk),
		.reset(reset),
		.bus(bus.seq)
	);

	instrDecoder i_instrDecoder (
		.clk(clk),
		.reset(reset),
		.op(op),
		.funct(funct),
		.bus(bus.dec)
	);

	controlWordTable #(.MemWaitSteps(MemWaitSteps)) i_controlWordTable (
		.bus(bus.tbl),
		.word(word)
	);

	// control word out to the datapath
	assign pcWriteCond = word.pcWriteCond;
	assign pcWrite = word.pcWrite;
	assign irWrite = word.irWrite;
	assign regWrite = word.regWrite;
	assign regAWrite = word.regAWrite;
	assign regBWrite = word.regBWrite;
	assign aluOutWrite = word.aluOutWrite;
	assign mdrWrite = word.mdrWrite;
	assign memRead = word.memRead;
	assign memWrite = word.memWrite;
	assign pcCondMux = word.pcCondMux;
	assign iorDMux = word.iorDMux;
	assign readSMux = word.readSMux;
	assign readDstMux = word.readDstMux;
	assign memToRegMux = word.memToRegMux;
	assign aluSrcAMux = word.aluSrcAMux;
	assign aluSrcBMux = word.aluSrcBMux;
	assign pcSourceMux = word.pcSourceMux;
	assign aluOp = word.aluOp;

	assign phase = bus.phase;
	assign instrDone = bus.lastStep && (bus.phase == mipsCtrlPkg::phExecute);

endmodule

`default_nettype wire

/* hdl/stepSequencer.sv */
`default_nettype none

module stepSequencer #(
	parameter int MemWaitSteps = 1
) (
	input logic clk,
	input logic reset,
	ctrlBus.seq bus
);

	localparam mipsCtrlPkg::stepT lastWaitStep = mipsCtrlPkg::stepT'(MemWaitSteps - 1);

	mipsCtrlPkg::phaseT phaseNext;
	mipsCtrlPkg::stepT stepNext;
	logic advance;

	// advance means leave the current phase
	always_comb begin
		case (bus.phase)
			mipsCtrlPkg::phReset: begin
				advance = 1'b1;
				phaseNext = mipsCtrlPkg::phFetch;
			end
			mipsCtrlPkg::phFetch: begin
				advance = 1'b1;
				phaseNext = mipsCtrlPkg::phWait;
			end
			mipsCtrlPkg::phWait: begin
				advance = (bus.step == lastWaitStep);
				phaseNext = advance ? mipsCtrlPkg::phDecode : mipsCtrlPkg::phWait;
			end
			mipsCtrlPkg::phDecode: begin
				advance = 1'b1;
				phaseNext = mipsCtrlPkg::phExecute;
			end
			mipsCtrlPkg::phExecute: begin
				// the table decides when the instruction is finished
				advance = bus.lastStep;
				phaseNext = advance ? mipsCtrlPkg::phFetch : mipsCtrlPkg::phExecute;
			end
			default: begin
				advance = 1'b1;
				phaseNext = mipsCtrlPkg::phReset;
			end
		endcase
		stepNext = advance ? '0 : bus.step + 1'b1;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			bus.phase <= mipsCtrlPkg::phReset;
			bus.step <= '0;
		end else begin
			bus.phase <= phaseNext;
			bus.step <= stepNext;
		end
	end

	waitStepInRange: assert property (
		@(posedge clk) disable iff (reset)
		bus.phase == mipsCtrlPkg::phWait |-> bus.step <= lastWaitStep
	);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert --top-module mipsControlTb \
	-f filelist.f -o mipsControlSim

./obj_dir/mipsControlSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* tests/controlGolden.txt */
// columns: op funct N, then the N expected execute control words (30 bits, hex)
// words are for MemWaitSteps = 1, the word FFFFFFFF ends the list
// branches beq bne ble bgt
04 00 1 200C010A
05 00 1 2008010F
06 00 1 2004010F
07 00 1 2000010F
// lw then sw, address, access, wait, final step
23 00 4 00800181 00220000 00600000 04000400
2B 00 4 00800181 00220000 00600000 00100000
// lui, j, jal
0F 00 1 04000800
02 00 1 10000020
03 00 2 00800000 14001010
// R-type add sub and slt
00 20 2 00800101 04002000
00 22 2 00800102 04002000
00 24 2 00800103 04002000
00 2A 2 00800104 04002000
// immediates addi addiu slti
08 00 2 00800181 04000000
09 00 2 00800181 04000000
0A 00 2 00800184 04000000
// funct is ignored outside the R-type group
08 2A 2 00800181 04000000
0A 22 2 00800184 04000000
// unknown opcodes
3F 00 1 00000000
11 20 1 00000000
// unknown R-type function codes
00 10 1 00000000
00 25 1 00000000
// back to back memory and branch traffic
23 00 4 00800181 00220000 00600000 04000400
04 00 1 200C010A
2B 00 4 00800181 00220000 00600000 00100000
07 00 1 2000010F
03 00 2 00800000 14001010
00 22 2 00800102 04002000
FFFFFFFF

/* tests/mipsControlTb.sv */
`default_nettype none

module mipsControlTb;

	localparam int MemWaitSteps = 1;
	localparam int GoldenDepth = 256;
	localparam int RandomInstrs = 8;
	localparam int ResetCycles = 10;
	localparam logic [31:0] EndMarker = 32'hffff_ffff;

	logic clk;
	logic reset;
	mipsCtrlPkg::opcodeT op;
	mipsCtrlPkg::functT funct;
	logic pcWriteCond, pcWrite, irWrite, regWrite, regAWrite, regBWrite;
	logic aluOutWrite, mdrWrite, memRead, memWrite, readSMux, aluSrcAMux;
	logic [1:0] pcCondMux, readDstMux, aluSrcBMux;
	logic [2:0] iorDMux, memToRegMux, pcSourceMux;
	mipsCtrlPkg::aluOpT aluOp;
	mipsCtrlPkg::phaseT phase;
	logic instrDone;

	mipsCtrlPkg::controlWordT dutWord;
	mipsCtrlPkg::controlWordT execWords [$];
	logic [31:0] golden [0:GoldenDepth-1];
	int cycleCount = 0;
	int cycleLimit = 1000000;
	integer seed;

	mipsControl #(.MemWaitSteps(MemWaitSteps)) i_mipsControl (
		.clk(clk), .reset(reset), .op(op), .funct(funct),
		.pcWriteCond(pcWriteCond), .pcWrite(pcWrite), .irWrite(irWrite),
		.regWrite(regWrite), .regAWrite(regAWrite), .regBWrite(regBWrite),
		.aluOutWrite(aluOutWrite), .mdrWrite(mdrWrite), .memRead(memRead),
		.memWrite(memWrite), .pcCondMux(pcCondMux), .iorDMux(iorDMux),
		.readSMux(readSMux), .readDstMux(readDstMux), .memToRegMux(memToRegMux),
		.aluSrcAMux(aluSrcAMux), .aluSrcBMux(aluSrcBMux), .pcSourceMux(pcSourceMux),
		.aluOp(aluOp), .phase(phase), .instrDone(instrDone)
	);

	// ports gathered back into one word
	assign dutWord = {pcWriteCond, pcWrite, irWrite, regWrite, regAWrite, regBWrite,
		aluOutWrite, mdrWrite, memRead, memWrite, pcCondMux, iorDMux, readSMux,
		readDstMux, memToRegMux, aluSrcAMux, aluSrcBMux, pcSourceMux, aluOp};

	always #5 clk = ~clk;

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			reportFailure("The run went past its cycle limit without finishing.");
		end
	end

	task automatic checkWord(input mipsCtrlPkg::controlWordT got,
			input mipsCtrlPkg::controlWordT exp, input string where);
		if (got !== exp) begin
			reportFailure($sformatf("Error: control word in %s got %h expected %h",
				where, got, exp));
		end
	endtask

	task automatic checkPhase(input mipsCtrlPkg::phaseT got, input mipsCtrlPkg::phaseT exp,
			input string where);
		if (got !== exp) begin
			reportFailure($sformatf("Error: phase in %s got %h expected %h", where, got, exp));
		end
	endtask

	task automatic checkDone(input logic got, input logic exp, input string where);
		if (got !== exp) begin
			reportFailure($sformatf("Error: instrDone in %s got %h expected %h",
				where, got, exp));
		end
	endtask

	task automatic checkCycle(input mipsCtrlPkg::phaseT expPhase,
			input mipsCtrlPkg::controlWordT expWord, input logic expDone, input string where);
		checkPhase(phase, expPhase, where);
		checkWord(dutWord, expWord, where);
		checkDone(instrDone, expDone, where);
	endtask

	function automatic mipsCtrlPkg::controlWordT fetchWord();
		mipsCtrlPkg::controlWordT w;
		w = '0;
		w.pcWrite = 1'b1;
		w.memRead = 1'b1;
		w.aluSrcBMux = 2'b01;
		w.aluOp = mipsCtrlPkg::aluAdd;
		return w;
	endfunction

	// instruction register loads in the last wait cycle
	function automatic mipsCtrlPkg::controlWordT waitWord(input logic last);
		mipsCtrlPkg::controlWordT w;
		w = '0;
		w.memRead = 1'b1;
		w.irWrite = last;
		return w;
	endfunction

	function automatic mipsCtrlPkg::controlWordT decodeWord();
		mipsCtrlPkg::controlWordT w;
		w = '0;
		w.regAWrite = 1'b1;
		w.regBWrite = 1'b1;
		w.aluOutWrite = 1'b1;
		w.readSMux = 1'b1;
		w.aluSrcBMux = 2'b11;
		w.aluOp = mipsCtrlPkg::aluAdd;
		return w;
	endfunction

	function automatic logic isKnownOp(input logic [5:0] opVal);
		return opVal inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
			6'h08, 6'h09, 6'h0a, 6'h0f, 6'h23, 6'h2b};
	endfunction

	// entered on the falling edge of fetch, leaves on the next fetch
	task automatic runInstr(input logic [5:0] opVal, input logic [5:0] functVal, input int n);
		string tag;
		int w;
		int s;
		tag = $sformatf("op %h funct %h", opVal, functVal);
		op = mipsCtrlPkg::opcodeT'(opVal);
		funct = mipsCtrlPkg::functT'(functVal);
		checkCycle(mipsCtrlPkg::phFetch, fetchWord(), 1'b0, {"fetch of ", tag});
		for (w = 0; w < MemWaitSteps; w++) begin
			@(negedge clk);
			checkCycle(mipsCtrlPkg::phWait, waitWord(w == MemWaitSteps - 1), 1'b0,
				{"wait of ", tag});
		end
		@(negedge clk);
		checkCycle(mipsCtrlPkg::phDecode, decodeWord(), 1'b0, {"decode of ", tag});
		for (s = 0; s < n; s++) begin
			@(negedge clk);
			checkCycle(mipsCtrlPkg::phExecute, execWords[s], s == n - 1,
				$sformatf("execute step %0d of %s", s, tag));
		end
		@(negedge clk);
		checkPhase(phase, mipsCtrlPkg::phFetch, {"cycle after ", tag});
	endtask

	initial begin
		int pos;
		int n;
		int s;
		int total;
		logic [5:0] randOp;
		clk = 1'b0;
		reset = 1'b1;
		op = mipsCtrlPkg::opRType;
		funct = mipsCtrlPkg::fnAdd;
		seed = 32'h86ca;
		for (pos = 0; pos < GoldenDepth; pos++) begin
			golden[8'(pos)] = EndMarker;
		end
		$readmemh("tests/controlGolden.txt", golden);
		if (golden[0] == EndMarker) begin
			reportFailure("The golden file is missing or holds no records.");
		end

		// expected length of the whole run sets the timeout
		total = ResetCycles + 1 + RandomInstrs * (3 + MemWaitSteps);
		pos = 0;
		while (pos < GoldenDepth - 3 && golden[8'(pos)] != EndMarker) begin
			n = int'(golden[8'(pos + 2)]);
			total += 2 + MemWaitSteps + n;
			pos += 3 + n;
		end
		cycleLimit = 2 * (total + 20);

		repeat (ResetCycles) begin
			@(negedge clk);
			checkCycle(mipsCtrlPkg::phReset, '0, 1'b0, "reset");
		end
		reset = 1'b0;
		#1;
		checkCycle(mipsCtrlPkg::phReset, '0, 1'b0, "first cycle after reset");
		@(negedge clk);

		pos = 0;
		while (pos < GoldenDepth - 3 && golden[8'(pos)] != EndMarker) begin
			n = int'(golden[8'(pos + 2)]);
			if (n < 1 || n > 8 || pos + 3 + n > GoldenDepth) begin
				reportFailure($sformatf("Golden record at word %0d has a bad step count.", pos));
			end
			execWords.delete();
			for (s = 0; s < n; s++) begin
				execWords.push_back(mipsCtrlPkg::controlWordT'(golden[8'(pos + 3 + s)][29:0]));
			end
			runInstr(golden[8'(pos)][5:0], golden[8'(pos + 1)][5:0], n);
			pos += 3 + n;
		end

		// unlisted opcodes all take the single noop step
		repeat (RandomInstrs) begin
			randOp = 6'($random(seed));
			while (isKnownOp(randOp)) begin
				randOp = 6'($random(seed));
			end
			execWords.delete();
			execWords.push_back('0);
			runInstr(randOp, 6'($random(seed)), 1);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
